// File: common/mem_port_defines.svh
`ifndef MEM_PORT_DEFINES_SVH
`define MEM_PORT_DEFINES_SVH

// number of interleaved ram banks, power of two
`define MP_BANKS 4

// bank index width, taken from the low word address bits
`define MP_BANK_BITS ($clog2(`MP_BANKS))

// words held in each bank
`define MP_BANK_DEPTH 256

// row index width inside one bank
`define MP_ROW_BITS ($clog2(`MP_BANK_DEPTH))

// top byte of a valid download header
`define MP_HDR_MARK 8'hA5

`endif

// File: common/mem_port_pkg.sv
`default_nettype none

`include "mem_port_defines.svh"

package mem_port_pkg;

	// one memory word, four byte lanes
	typedef logic [31:0] mp_word_t;

	// byte address
	// bits 1:0 never reach the banks
	typedef logic [23:0] mp_addr_t;

	// byte lane enables, bit 0 is bits 7:0 of the word
	typedef logic [3:0] mp_sel_t;

	// bank number from the low word address bits
	typedef logic [`MP_BANK_BITS-1:0] mp_bank_t;

	// word assembled by the image loader
	// first word of a download goes through hdr, the rest through raw
	typedef union packed {
		mp_word_t raw;
		struct packed {
			// must match MP_HDR_MARK
			logic [7:0] mark;
			// lane select for every later write
			mp_sel_t sel;
			// word address of the first data word
			logic [19:0] start_wadr;
		} hdr;
	} mp_load_word_u;

endpackage

`default_nettype wire

// File: src/image_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_port_defines.svh"

module image_loader (
	input logic clk_32m,
	input logic rst_n_i,
	input logic ld_active_i,
	input logic ld_valid_i,
	input logic [7:0] ld_byte_i,
	output logic ld_ready_o,
	output logic wr_stb_o,
	output mem_port_pkg::mp_sel_t wr_sel_o,
	output mem_port_pkg::mp_addr_t wr_adr_o,
	output mem_port_pkg::mp_word_t wr_dat_o,
	input logic wr_ack_i
);

	mem_port_pkg::mp_load_word_u word_q;
	mem_port_pkg::mp_load_word_u word_next;
	logic [1:0] byte_cnt_q;
	logic hdr_pending_q;
	logic hdr_ok_q;
	logic [21:0] wadr_q;
	logic byte_take;
	logic word_done;

	// no new bytes while a write waits for its ack
	assign ld_ready_o = ~wr_stb_o;
	assign byte_take = ld_active_i & ld_valid_i & ld_ready_o;
	assign word_done = byte_take & (byte_cnt_q == 2'd3);

	// little endian, newest byte enters at the top
	always_comb begin
		word_next.raw = {ld_byte_i, word_q.raw[31:8]};
	end

	always_ff @(posedge clk_32m) begin
		if (byte_take) begin
			word_q <= word_next;
		end
	end

	always_ff @(posedge clk_32m) begin
		if (!rst_n_i) begin
			byte_cnt_q <= 2'd0;
			hdr_pending_q <= 1'b1;
			hdr_ok_q <= 1'b0;
			wr_stb_o <= 1'b0;
		end else begin
			// strobe held until the memory answers
			if (wr_stb_o && wr_ack_i) begin
				wr_stb_o <= 1'b0;
			end
			if (!ld_active_i) begin
				// idle, next download starts with a header again
				byte_cnt_q <= 2'd0;
				hdr_pending_q <= 1'b1;
				hdr_ok_q <= 1'b0;
			end else if (byte_take) begin
				byte_cnt_q <= byte_cnt_q + 2'd1;
				if (word_done) begin
					if (hdr_pending_q) begin
						hdr_pending_q <= 1'b0;
						// bad marker, rest of this download is dropped
						hdr_ok_q <= (word_next.hdr.mark == `MP_HDR_MARK);
					end else if (hdr_ok_q) begin
						wr_stb_o <= 1'b1;
					end
				end
			end
		end
	end

	// write fields, loaded from the header or the finished word
	always_ff @(posedge clk_32m) begin
		if (word_done) begin
			if (hdr_pending_q) begin
				wadr_q <= {2'b00, word_next.hdr.start_wadr};
				wr_sel_o <= word_next.hdr.sel;
			end else begin
				wr_dat_o <= word_next.raw;
			end
		end
		// next word address once the write is done
		if (wr_stb_o && wr_ack_i) begin
			wadr_q <= wadr_q + 22'd1;
		end
	end

	assign wr_adr_o = {wadr_q, 2'b00};

endmodule

`default_nettype wire

// File: src/bus_owner.sv
`timescale 1ns/1ps
`default_nettype none

module bus_owner (
	input logic clk_32m,
	input logic rst_n_i,
	input logic ld_active_i,
	input logic wr_stb_i,
	input mem_port_pkg::mp_sel_t wr_sel_i,
	input mem_port_pkg::mp_addr_t wr_adr_i,
	input mem_port_pkg::mp_word_t wr_dat_i,
	output logic wr_ack_o,
	input logic core_stb_i,
	input logic core_we_i,
	input mem_port_pkg::mp_sel_t core_sel_i,
	input mem_port_pkg::mp_addr_t core_adr_i,
	input mem_port_pkg::mp_word_t core_dat_i,
	output logic core_ack_o,
	output mem_port_pkg::mp_word_t core_dat_o,
	output logic mem_stb_o,
	output logic mem_we_o,
	output mem_port_pkg::mp_sel_t mem_sel_o,
	output mem_port_pkg::mp_addr_t mem_adr_o,
	output mem_port_pkg::mp_word_t mem_wdat_o,
	input logic mem_ack_i,
	input mem_port_pkg::mp_word_t mem_rdat_i
);

	// high while the loader owns the memory
	logic owner_ld_q;

	// ownership only moves between cycles of the current owner
	// a strobe is held through its ack, so a low strobe means idle
	always_ff @(posedge clk_32m) begin
		if (!rst_n_i) begin
			owner_ld_q <= 1'b0;
		end else if (!owner_ld_q && ld_active_i && !core_stb_i) begin
			owner_ld_q <= 1'b1;
		end else if (owner_ld_q && !ld_active_i && !wr_stb_i) begin
			owner_ld_q <= 1'b0;
		end
	end

	// request from the owner only
	// the other master waits with its strobe up
	assign mem_stb_o = owner_ld_q ? wr_stb_i : core_stb_i;
	// loader only ever writes
	assign mem_we_o = owner_ld_q ? 1'b1 : core_we_i;
	assign mem_sel_o = owner_ld_q ? wr_sel_i : core_sel_i;
	assign mem_adr_o = owner_ld_q ? wr_adr_i : core_adr_i;
	assign mem_wdat_o = owner_ld_q ? wr_dat_i : core_dat_i;

	// ack goes back to the owner only
	assign wr_ack_o = owner_ld_q & mem_ack_i;
	assign core_ack_o = ~owner_ld_q & mem_ack_i;

	// read data only counts together with core_ack_o
	assign core_dat_o = mem_rdat_i;

endmodule

`default_nettype wire

// File: bank/bank_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_port_defines.svh"

module bank_router (
	input logic mem_stb_i,
	input logic mem_we_i,
	input mem_port_pkg::mp_sel_t mem_sel_i,
	input mem_port_pkg::mp_addr_t mem_adr_i,
	input mem_port_pkg::mp_word_t mem_wdat_i,
	output logic [`MP_BANKS-1:0] bank_stb_o,
	output logic bank_we_o,
	output mem_port_pkg::mp_sel_t bank_sel_o,
	output logic [`MP_ROW_BITS-1:0] bank_row_o,
	output mem_port_pkg::mp_word_t bank_wdat_o
);

	mem_port_pkg::mp_bank_t bank_idx;

	// word address starts at bit 2
	// low word bits pick the bank, so neighbours interleave
	assign bank_idx = mem_adr_i[2 +: `MP_BANK_BITS];
	// row sits right above the bank bits, upper bits alias
	assign bank_row_o = mem_adr_i[2 + `MP_BANK_BITS +: `MP_ROW_BITS];

	// one hot strobe, only the addressed bank sees the cycle
	always_comb begin
		bank_stb_o = '0;
		for (int b = 0; b < `MP_BANKS; b++) begin
			if (mem_stb_i && (bank_idx == mem_port_pkg::mp_bank_t'(b))) begin
				bank_stb_o[b] = 1'b1;
			end
		end
	end

	// shared fields fan out to every bank
	assign bank_we_o = mem_we_i;
	assign bank_sel_o = mem_sel_i;
	assign bank_wdat_o = mem_wdat_i;

endmodule

`default_nettype wire

// File: bank/ram_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_port_defines.svh"

module ram_bank (
	input logic clk_32m,
	input logic rst_n_i,
	input logic stb_i,
	input logic we_i,
	input mem_port_pkg::mp_sel_t sel_i,
	input logic [`MP_ROW_BITS-1:0] row_i,
	input mem_port_pkg::mp_word_t wdat_i,
	output logic ack_o,
	output mem_port_pkg::mp_word_t rdat_o
);

	mem_port_pkg::mp_word_t mem_q [`MP_BANK_DEPTH];
	// access in progress, two stages before the ack
	logic [1:0] busy_q;
	// cycle after ack, master still holds its strobe
	logic guard_q;
	logic take;

	// new access only when fully idle
	assign take = stb_i & ~(|busy_q) & ~ack_o & ~guard_q;

	// storage and registered read
	always_ff @(posedge clk_32m) begin
		if (take) begin
			// old word is returned, also on a write
			rdat_o <= mem_q[row_i];
			if (we_i) begin
				for (int l = 0; l < 4; l++) begin
					if (sel_i[l]) begin
						mem_q[row_i][8*l +: 8] <= wdat_i[8*l +: 8];
					end
				end
			end
		end
	end

	// take at edge 0, ack after edge 2, guard after edge 3
	always_ff @(posedge clk_32m) begin
		if (!rst_n_i) begin
			busy_q <= 2'b00;
			ack_o <= 1'b0;
			guard_q <= 1'b0;
		end else begin
			busy_q <= {busy_q[0], take};
			ack_o <= busy_q[1];
			guard_q <= ack_o;
		end
	end

endmodule

`default_nettype wire

// File: bank/ack_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_port_defines.svh"

module ack_merge (
	input logic clk_32m,
	input logic rst_n_i,
	input logic [`MP_BANKS-1:0] bank_ack_i,
	input mem_port_pkg::mp_word_t bank_rdat_i [`MP_BANKS],
	output logic mem_ack_o,
	output mem_port_pkg::mp_word_t mem_rdat_o
);

	logic any_ack;
	mem_port_pkg::mp_word_t rdat_sel;

	// at most one bank answers, one cycle in flight
	always_comb begin
		any_ack = |bank_ack_i;
		rdat_sel = '0;
		for (int b = 0; b < `MP_BANKS; b++) begin
			if (bank_ack_i[b]) begin
				rdat_sel = rdat_sel | bank_rdat_i[b];
			end
		end
	end

	always_ff @(posedge clk_32m) begin
		if (!rst_n_i) begin
			mem_ack_o <= 1'b0;
		end else begin
			mem_ack_o <= any_ack;
		end
	end

	// data held until the next answering bank
	always_ff @(posedge clk_32m) begin
		if (any_ack) begin
			mem_rdat_o <= rdat_sel;
		end
	end

endmodule

`default_nettype wire

// File: src/mem_port_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_port_defines.svh"

module mem_port_top (
	input logic clk_32m,
	input logic rst_n_i,
	input logic core_stb_i,
	input logic core_we_i,
	input mem_port_pkg::mp_sel_t core_sel_i,
	input mem_port_pkg::mp_addr_t core_adr_i,
	input mem_port_pkg::mp_word_t core_dat_i,
	output logic core_ack_o,
	output mem_port_pkg::mp_word_t core_dat_o,
	input logic ld_active_i,
	input logic ld_valid_i,
	input logic [7:0] ld_byte_i,
	output logic ld_ready_o
);

	// loader write request
	logic wr_stb;
	mem_port_pkg::mp_sel_t wr_sel;
	mem_port_pkg::mp_addr_t wr_adr;
	mem_port_pkg::mp_word_t wr_dat;
	logic wr_ack;

	// shared request after ownership
	logic mem_stb;
	logic mem_we;
	mem_port_pkg::mp_sel_t mem_sel;
	mem_port_pkg::mp_addr_t mem_adr;
	mem_port_pkg::mp_word_t mem_wdat;
	logic mem_ack;
	mem_port_pkg::mp_word_t mem_rdat;

	// bank side
	logic [`MP_BANKS-1:0] bank_stb;
	logic bank_we;
	mem_port_pkg::mp_sel_t bank_sel;
	logic [`MP_ROW_BITS-1:0] bank_row;
	mem_port_pkg::mp_word_t bank_wdat;
	logic [`MP_BANKS-1:0] bank_ack;
	mem_port_pkg::mp_word_t bank_rdat [`MP_BANKS];

	image_loader image_loader_inst (
		.clk_32m     (clk_32m),
		.rst_n_i     (rst_n_i),
		.ld_active_i (ld_active_i),
		.ld_valid_i  (ld_valid_i),
		.ld_byte_i   (ld_byte_i),
		.ld_ready_o  (ld_ready_o),
		.wr_stb_o    (wr_stb),
		.wr_sel_o    (wr_sel),
		.wr_adr_o    (wr_adr),
		.wr_dat_o    (wr_dat),
		.wr_ack_i    (wr_ack)
	);

	bus_owner bus_owner_inst (
		.clk_32m     (clk_32m),
		.rst_n_i     (rst_n_i),
		.ld_active_i (ld_active_i),
		.wr_stb_i    (wr_stb),
		.wr_sel_i    (wr_sel),
		.wr_adr_i    (wr_adr),
		.wr_dat_i    (wr_dat),
		.wr_ack_o    (wr_ack),
		.core_stb_i  (core_stb_i),
		.core_we_i   (core_we_i),
		.core_sel_i  (core_sel_i),
		.core_adr_i  (core_adr_i),
		.core_dat_i  (core_dat_i),
		.core_ack_o  (core_ack_o),
		.core_dat_o  (core_dat_o),
		.mem_stb_o   (mem_stb),
		.mem_we_o    (mem_we),
		.mem_sel_o   (mem_sel),
		.mem_adr_o   (mem_adr),
		.mem_wdat_o  (mem_wdat),
		.mem_ack_i   (mem_ack),
		.mem_rdat_i  (mem_rdat)
	);

	bank_router bank_router_inst (
		.mem_stb_i   (mem_stb),
		.mem_we_i    (mem_we),
		.mem_sel_i   (mem_sel),
		.mem_adr_i   (mem_adr),
		.mem_wdat_i  (mem_wdat),
		.bank_stb_o  (bank_stb),
		.bank_we_o   (bank_we),
		.bank_sel_o  (bank_sel),
		.bank_row_o  (bank_row),
		.bank_wdat_o (bank_wdat)
	);

	// one bank per strobe bit
	for (genvar b = 0; b < `MP_BANKS; b++) begin : g_bank
		ram_bank ram_bank_inst (
			.clk_32m (clk_32m),
			.rst_n_i (rst_n_i),
			.stb_i   (bank_stb[b]),
			.we_i    (bank_we),
			.sel_i   (bank_sel),
			.row_i   (bank_row),
			.wdat_i  (bank_wdat),
			.ack_o   (bank_ack[b]),
			.rdat_o  (bank_rdat[b])
		);
	end

	ack_merge ack_merge_inst (
		.clk_32m     (clk_32m),
		.rst_n_i     (rst_n_i),
		.bank_ack_i  (bank_ack),
		.bank_rdat_i (bank_rdat),
		.mem_ack_o   (mem_ack),
		.mem_rdat_o  (mem_rdat)
	);

endmodule

`default_nettype wire

// File: verif/mem_port_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_props (
	input logic clk_32m,
	input logic rst_n_i,
	input logic core_stb_i,
	input logic core_ack_i,
	input logic wr_stb_i,
	input logic wr_ack_i,
	input logic mem_ack_i
);

	// wishbone classic, strobe held until the ack
	core_stb_held: assert property (@(posedge clk_32m) disable iff (!rst_n_i)
		core_stb_i && !core_ack_i |=> core_stb_i)
		else $error("core strobe dropped before its acknowledge");

	// no ack without an open cycle of the same master
	core_ack_has_stb: assert property (@(posedge clk_32m) disable iff (!rst_n_i)
		core_ack_i |-> core_stb_i)
		else $error("core acknowledge without a core strobe");

	loader_ack_has_stb: assert property (@(posedge clk_32m) disable iff (!rst_n_i)
		wr_ack_i |-> wr_stb_i)
		else $error("loader acknowledge without a loader strobe");

	// merged ack is a single pulse
	mem_ack_pulse: assert property (@(posedge clk_32m) disable iff (!rst_n_i)
		mem_ack_i |=> !mem_ack_i)
		else $error("memory acknowledge longer than one cycle");

endmodule

`default_nettype wire

// File: verif/mem_port_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_port_defines.svh"

module mem_port_tb;

	// cycles any single wait may take
	localparam int WAIT_LIMIT = 200;
	// core ack after the first strobe edge
	localparam int CORE_LATENCY = 3;

	logic clk_32m;
	logic rst_n;
	logic core_stb;
	logic core_we;
	mem_port_pkg::mp_sel_t core_sel;
	mem_port_pkg::mp_addr_t core_adr;
	mem_port_pkg::mp_word_t core_wdat;
	logic core_ack;
	mem_port_pkg::mp_word_t core_rdat;
	logic ld_active;
	logic ld_valid;
	logic [7:0] ld_byte;
	logic ld_ready;

	int check_cnt;
	int error_cnt;
	int timeout_cnt;
	logic timed_out;

	// expected memory, indexed by {row, bank}
	mem_port_pkg::mp_word_t shadow [`MP_BANKS*`MP_BANK_DEPTH];

	// reference loader state
	logic model_hdr_pending;
	logic model_hdr_ok;
	mem_port_pkg::mp_sel_t model_sel;
	logic [21:0] model_wadr;
	mem_port_pkg::mp_word_t model_word;
	int model_cnt;

	// core read held open during a download
	logic posted;
	mem_port_pkg::mp_addr_t posted_adr;
	mem_port_pkg::mp_word_t posted_exp;
	string posted_name;

	mem_port_top mem_port_top_inst (
		.clk_32m    (clk_32m),
		.rst_n_i    (rst_n),
		.core_stb_i (core_stb),
		.core_we_i  (core_we),
		.core_sel_i (core_sel),
		.core_adr_i (core_adr),
		.core_dat_i (core_wdat),
		.core_ack_o (core_ack),
		.core_dat_o (core_rdat),
		.ld_active_i (ld_active),
		.ld_valid_i (ld_valid),
		.ld_byte_i  (ld_byte),
		.ld_ready_o (ld_ready)
	);

	bind bus_owner mem_port_props mem_port_props_inst (
		.clk_32m    (clk_32m),
		.rst_n_i    (rst_n_i),
		.core_stb_i (core_stb_i),
		.core_ack_i (core_ack_o),
		.wr_stb_i   (wr_stb_i),
		.wr_ack_i   (wr_ack_o),
		.mem_ack_i  (mem_ack_i)
	);

	initial begin
		clk_32m = 1'b0;
		forever begin
			#2 clk_32m = ~clk_32m;
		end
	end

	// core must wait while the loader owns the memory
	always @(negedge clk_32m) begin
		if (ld_active && core_ack) begin
			error_cnt++;
			$display("core acknowledge seen while a download is still active");
		end
	end

	task automatic check_word(input string name, input mem_port_pkg::mp_word_t exp,
			input mem_port_pkg::mp_word_t got);
		check_cnt++;
		if (got !== exp) begin
			error_cnt++;
			$display("error %s expected %h actual %h", name, exp, got);
		end
	endtask

	task automatic check_latency(input string name, input int exp, input int got);
		check_cnt++;
		if (got != exp) begin
			error_cnt++;
			$display("error %s latency expected %0d actual %0d", name, exp, got);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		check_cnt++;
		if (got !== exp) begin
			error_cnt++;
			$display("error %s expected %b actual %b", name, exp, got);
		end
	endtask

	// word address bits 1:0 pick the bank, the next eight the row
	function automatic logic [9:0] shadow_index(input mem_port_pkg::mp_addr_t adr);
		logic [1:0] bank;
		logic [7:0] row;
		bank = adr[3:2];
		row = adr[11:4];
		return {row, bank};
	endfunction

	task automatic shadow_write(input mem_port_pkg::mp_addr_t adr,
			input mem_port_pkg::mp_sel_t sel, input mem_port_pkg::mp_word_t dat);
		logic [9:0] idx;
		idx = shadow_index(adr);
		for (int l = 0; l < 4; l++) begin
			if (sel[l]) begin
				shadow[idx][8*l +: 8] = dat[8*l +: 8];
			end
		end
	endtask

	task automatic model_reset();
		model_hdr_pending = 1'b1;
		model_hdr_ok = 1'b0;
		model_cnt = 0;
		model_word = '0;
	endtask

	// little endian bytes, first word is the header
	task automatic model_take_byte(input logic [7:0] b);
		model_word = {b, model_word[31:8]};
		model_cnt++;
		if (model_cnt == 4) begin
			model_cnt = 0;
			if (model_hdr_pending) begin
				model_hdr_pending = 1'b0;
				// marker in the top byte, then lanes, then start word
				model_hdr_ok = (model_word[31:24] == `MP_HDR_MARK);
				model_sel = model_word[23:20];
				model_wadr = {2'b00, model_word[19:0]};
			end else if (model_hdr_ok) begin
				shadow_write({model_wadr, 2'b00}, model_sel, model_word);
				model_wadr = model_wadr + 22'd1;
			end
		end
	endtask

	task automatic raise_core(input logic we, input mem_port_pkg::mp_sel_t sel,
			input mem_port_pkg::mp_addr_t adr, input mem_port_pkg::mp_word_t dat);
		@(posedge clk_32m);
		#0.5;
		core_stb = 1'b1;
		core_we = we;
		core_sel = sel;
		core_adr = adr;
		core_wdat = dat;
	endtask

	// counts edges after the first strobe edge, then closes the cycle
	task automatic wait_core_ack(output mem_port_pkg::mp_word_t rdat, output int cycles);
		cycles = 0;
		rdat = '0;
		@(negedge clk_32m);
		while (!core_ack && cycles < WAIT_LIMIT) begin
			@(posedge clk_32m);
			cycles++;
			@(negedge clk_32m);
		end
		if (core_ack) begin
			rdat = core_rdat;
		end else begin
			timeout_cnt++;
			timed_out = 1'b1;
			$display("timeout waiting for the core acknowledge at address %h", core_adr);
		end
		@(posedge clk_32m);
		#0.5;
		core_stb = 1'b0;
		core_we = 1'b0;
	endtask

	task automatic run_core(input string name, input logic we,
			input mem_port_pkg::mp_sel_t sel, input mem_port_pkg::mp_addr_t adr,
			input mem_port_pkg::mp_word_t dat, output mem_port_pkg::mp_word_t rdat);
		int cycles;
		raise_core(we, sel, adr, dat);
		// first edge with the strobe high
		@(posedge clk_32m);
		wait_core_ack(rdat, cycles);
		if (!timed_out) begin
			check_latency(name, CORE_LATENCY, cycles);
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		int waited;
		int gap;
		@(posedge clk_32m);
		#0.5;
		ld_valid = 1'b1;
		ld_byte = b;
		waited = 0;
		@(negedge clk_32m);
		while (!ld_ready && waited < WAIT_LIMIT) begin
			@(negedge clk_32m);
			waited++;
		end
		if (!ld_ready) begin
			timeout_cnt++;
			timed_out = 1'b1;
			$display("timeout waiting for the loader to accept byte %h", b);
		end
		// byte moves on this edge
		@(posedge clk_32m);
		#0.5;
		ld_valid = 1'b0;
		gap = int'($urandom % 3);
		for (int g = 0; g < gap; g++) begin
			@(posedge clk_32m);
		end
	endtask

	task automatic finish_download();
		int waited;
		int cycles;
		mem_port_pkg::mp_word_t rdat;
		@(posedge clk_32m);
		#0.5;
		ld_active = 1'b0;
		ld_valid = 1'b0;
		// held read completes once ownership is back
		if (posted) begin
			wait_core_ack(rdat, cycles);
			posted = 1'b0;
			if (!timed_out) begin
				check_word(posted_name, posted_exp, rdat);
				check_word({posted_name, " shadow"}, shadow[shadow_index(posted_adr)], rdat);
			end
		end
		waited = 0;
		@(negedge clk_32m);
		while (!ld_ready && waited < WAIT_LIMIT) begin
			@(negedge clk_32m);
			waited++;
		end
		if (!ld_ready) begin
			timeout_cnt++;
			timed_out = 1'b1;
			$display("timeout waiting for the loader to finish its last write");
		end
		// owner register follows one edge after the loader strobe
		repeat (2) @(posedge clk_32m);
		model_reset();
	endtask

	initial begin : main_flow
		int unsigned seed_val;
		int fd;
		int n;
		int lineno;
		string line;
		string name;
		logic [7:0] op;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		mem_port_pkg::mp_word_t rdat;
		check_cnt = 0;
		error_cnt = 0;
		timeout_cnt = 0;
		timed_out = 1'b0;
		posted = 1'b0;
		rst_n = 1'b0;
		core_stb = 1'b0;
		core_we = 1'b0;
		core_sel = '0;
		core_adr = '0;
		core_wdat = '0;
		ld_active = 1'b0;
		ld_valid = 1'b0;
		ld_byte = '0;
		model_sel = '0;
		model_wadr = '0;
		model_reset();
		seed_val = $urandom(32'ha4db);
		repeat (16) @(posedge clk_32m);
		#0.5;
		rst_n = 1'b1;
		@(negedge clk_32m);
		check_flag("reset core ack", 1'b0, core_ack);
		check_flag("reset loader ready", 1'b1, ld_ready);
		lineno = 0;
		fd = $fopen("verif/mem_port_trace.txt", "r");
		if (fd == 0) begin
			error_cnt++;
			$display("could not open the trace file verif/mem_port_trace.txt");
		end else begin
			while (!timed_out && $fgets(line, fd) > 0) begin
				lineno++;
				if (line.len() < 2 || line.getc(0) == "#") begin
					continue;
				end
				n = $sscanf(line, "%c %h %h %h", op, f1, f2, f3);
				case (op)
					"W": begin
						name = $sformatf("line %0d write %h", lineno, f1[23:0]);
						run_core(name, 1'b1, f2[3:0], f1[23:0], f3, rdat);
						shadow_write(f1[23:0], f2[3:0], f3);
					end
					"R": begin
						name = $sformatf("line %0d read %h", lineno, f1[23:0]);
						if (ld_active) begin
							// left open until the download ends
							raise_core(1'b0, 4'hf, f1[23:0], '0);
							posted = 1'b1;
							posted_adr = f1[23:0];
							posted_exp = f2;
							posted_name = name;
						end else begin
							run_core(name, 1'b0, 4'hf, f1[23:0], '0, rdat);
							if (!timed_out) begin
								check_word(name, f2, rdat);
								check_word({name, " shadow"}, shadow[shadow_index(f1[23:0])],
									rdat);
							end
						end
					end
					"B": begin
						if (!ld_active) begin
							@(posedge clk_32m);
							#0.5;
							ld_active = 1'b1;
						end
						send_byte(f1[7:0]);
						model_take_byte(f1[7:0]);
					end
					"E": begin
						finish_download();
					end
					default: begin
						error_cnt++;
						$display("unknown operation in trace line %0d", lineno);
					end
				endcase
			end
			$fclose(fd);
		end
		$display("checks %0d, errors %0d, timeouts %0d", check_cnt, error_cnt, timeout_cnt);
		if (error_cnt == 0 && timeout_cnt == 0 && check_cnt > 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/mem_port_trace.txt
# op, then hex fields: W adr sel data = core write, R adr word = core read and expected word
# B byte = loader byte (download starts on the first one), E = loader end
W 000100 f 11223344
W 000100 5 aabbccdd
R 000100 11bb33dd
W 000200 f 01020304
W 000204 f 05060708
W 000208 f 090a0b0c
W 00020c f 0d0e0f10
R 000200 01020304
R 000204 05060708
R 000208 090a0b0c
R 00020c 0d0e0f10
R 00f208 090a0b0c
R 123200 01020304
# header a5f00100, then two words
B 00
B 01
B f0
B a5
B 01
B 00
B fe
B ca
B 02
B 00
B ef
B be
E
R 000400 cafe0001
R 000404 beef0002
# header a5300100 with lanes 1:0, read held open during the download
B 00
B 01
B 30
B a5
R 000400 cafe7766
B 66
B 77
B 88
B 99
E
R 000404 beef0002
# header without the marker
B 01
B 01
B f0
B 00
B ef
B be
B ad
B de
E
R 000404 beef0002

// File: project.f
+incdir+common
common/mem_port_pkg.sv
src/image_loader.sv
src/bus_owner.sv
bank/bank_router.sv
bank/ram_bank.sv
bank/ack_merge.sv
src/mem_port_top.sv
verif/mem_port_props.sv
verif/mem_port_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module mem_port_tb

./obj_dir/Vmem_port_tb > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
grep -q "Simulation finished: PASS" sim.log
